// ==== mipsCtrlPkg.sv ====
// MIPS control path definitions
package mipsCtrlPkg;

    // ------------------------------
    // instruction fields
    // ------------------------------
    typedef enum logic [5:0] {
        opRtype = 6'h00,
        opJ     = 6'h02,
        opJal   = 6'h03,
        opBne   = 6'h05,
        opXori  = 6'h0e,
        opLw    = 6'h23,
        opSw    = 6'h2b
    } opcodeE;

    typedef enum logic [5:0] {
        fnJr  = 6'h08,
        fnAdd = 6'h20,
        fnSub = 6'h22,
        fnSlt = 6'h2a
    } functE;

    typedef enum logic [2:0] {
        aluAdd  = 3'b010,
        aluSub  = 3'b110,
        aluSlt  = 3'b111,
        aluXor  = 3'b011,
        aluPass = 3'b101
    } aluCtrlE;

    // ------------------------------
    // per-stage control slices
    // ------------------------------
    typedef struct packed {
        logic    valid;
        aluCtrlE aluCtrl;
        logic    aluSrc;                  // immediate operand.
        logic    regDst;                  // rd instead of rt.
    } exCtrlT;

    typedef struct packed {
        logic valid;
        logic memWrite;
        logic branch;
        logic jump;
    } memCtrlT;

    typedef struct packed {
        logic valid;
        logic regWrite;
        logic memToReg;
        logic link;                       // write return address to $ra.
    } wbCtrlT;

    typedef struct packed {
        exCtrlT  ex;
        memCtrlT mem;
        wbCtrlT  wb;
    } ctrlWordT;

    // APB register map
    typedef enum logic [3:0] {
        regPush    = 4'h0,
        regRetired = 4'h4,
        regIllegal = 4'h8
    } regAddrE;

endpackage

// ==== instrApbPort.sv ====
// APB instruction port
`timescale 1ns/1ps

module instrApbPort (
    input  logic        clk,
    input  logic        rst,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [3:0]  paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    input  logic        full,
    output logic        push,
    output logic [31:0] pushData,
    input  logic [31:0] retiredCount,
    input  logic [31:0] illegalCount
);
    import mipsCtrlPkg::*;

    logic        setup;
    logic        access;
    logic        pushHit;
    logic        readOnlyHit;
    logic        addrErr;
    logic [31:0] rdData;

    assign setup  = psel && !penable;
    assign access = psel && penable;

    // ------------------------------
    // address decode
    // ------------------------------
    assign pushHit     = (paddr == regPush);
    assign readOnlyHit = (paddr == regRetired) || (paddr == regIllegal);
    assign addrErr     = !(pushHit || readOnlyHit) || (pwrite && readOnlyHit);

    // wait state only for instruction writes into a full queue.
    assign pready  = access && !(pwrite && pushHit && full);
    assign pslverr = access && addrErr;

    assign push     = access && pwrite && pushHit && !full;
    assign pushData = pwdata;

    always_comb begin
        case (paddr)
            regRetired: rdData = retiredCount;
            regIllegal: rdData = illegalCount;
            default:    rdData = 32'd0;
        endcase
    end

    // sampled in the setup phase, presented in access.
    always_ff @(posedge clk) begin
        if (rst) begin
            prdata <= 32'd0;
        end else if (setup && !pwrite) begin
            prdata <= rdData;
        end
    end

endmodule

// ==== instrQueue.sv ====
// Instruction word FIFO
`timescale 1ns/1ps

module instrQueue #(
    parameter int QueueDepth = 4
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        push,
    input  logic [31:0] pushData,
    output logic        full,
    input  logic        pop,
    output logic        notEmpty,
    output logic [31:0] headData
);
    localparam int PtrW = (QueueDepth > 1) ? $clog2(QueueDepth) : 1;
    localparam int CntW = $clog2(QueueDepth + 1);

    logic [31:0]     mem [QueueDepth];
    logic [PtrW-1:0] wrPtr;
    logic [PtrW-1:0] rdPtr;
    logic [CntW-1:0] count;
    logic            wrEn;
    logic            rdEn;

    assign full     = (count == CntW'(QueueDepth));
    assign notEmpty = (count != '0);
    assign headData = mem[rdPtr];

    assign wrEn = push && !full;
    assign rdEn = pop && notEmpty;

    always_ff @(posedge clk) begin
        if (wrEn) begin
            mem[wrPtr] <= pushData;
        end
    end

    // pointers wrap at the depth, which need not be a power of two.
    always_ff @(posedge clk) begin
        if (rst) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (wrEn) begin
                wrPtr <= (wrPtr == PtrW'(QueueDepth - 1)) ? '0 : wrPtr + 1'b1;
            end
            if (rdEn) begin
                rdPtr <= (rdPtr == PtrW'(QueueDepth - 1)) ? '0 : rdPtr + 1'b1;
            end
            case ({wrEn, rdEn})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// ==== ctrlDecoder.sv ====
// Main control decoder
`timescale 1ns/1ps

module ctrlDecoder (
    input  logic [31:0]          instr,
    output mipsCtrlPkg::ctrlWordT ctrl,
    output logic                 illegal
);
    import mipsCtrlPkg::*;

    opcodeE opcode;
    functE  funct;

    assign opcode = opcodeE'(instr[31:26]);
    assign funct  = functE'(instr[5:0]);

    // valid bits stay low, the pipeline owns them.
    always_comb begin
        ctrl    = '0;
        illegal = 1'b0;
        case (opcode)
            opLw: begin
                ctrl.wb.regWrite = 1'b1;
                ctrl.wb.memToReg = 1'b1;
                ctrl.ex.aluSrc   = 1'b1;
                ctrl.ex.aluCtrl  = aluAdd;
            end
            opSw: begin
                ctrl.mem.memWrite = 1'b1;
                ctrl.ex.aluSrc    = 1'b1;
                ctrl.ex.aluCtrl   = aluAdd;
            end
            opBne: begin
                ctrl.mem.branch = 1'b1;
                ctrl.ex.aluCtrl = aluSub;          // compare by subtraction.
            end
            opXori: begin
                ctrl.wb.regWrite = 1'b1;
                ctrl.ex.aluSrc   = 1'b1;
                ctrl.ex.aluCtrl  = aluXor;
            end
            opJ: begin
                ctrl.mem.jump   = 1'b1;
                ctrl.ex.aluCtrl = aluPass;
            end
            opJal: begin
                ctrl.mem.jump    = 1'b1;
                ctrl.wb.regWrite = 1'b1;
                ctrl.wb.link     = 1'b1;
                ctrl.ex.aluCtrl  = aluPass;
            end
            opRtype: begin
                ctrl.wb.regWrite = 1'b1;
                ctrl.ex.regDst   = 1'b1;
                case (funct)
                    fnAdd: ctrl.ex.aluCtrl = aluAdd;
                    fnSub: ctrl.ex.aluCtrl = aluSub;
                    fnSlt: ctrl.ex.aluCtrl = aluSlt;
                    fnJr: begin
                        ctrl             = '0;   // jr writes no register.
                        ctrl.mem.jump    = 1'b1;
                        ctrl.ex.aluCtrl  = aluPass;
                    end
                    default: begin
                        ctrl    = '0;
                        illegal = 1'b1;
                    end
                endcase
            end
            default: begin
                illegal = 1'b1;
            end
        endcase
    end

endmodule

// ==== ctrlPipeline.sv ====
// Control stage registers
`timescale 1ns/1ps

module ctrlPipeline (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 notEmpty,
    output logic                 pop,
    input  mipsCtrlPkg::ctrlWordT ctrl,
    input  logic                 illegal,
    output mipsCtrlPkg::exCtrlT   exCtrl,
    output mipsCtrlPkg::memCtrlT  memCtrl,
    output mipsCtrlPkg::wbCtrlT   wbCtrl,
    output logic [31:0]          retiredCount,
    output logic [31:0]          illegalCount
);
    import mipsCtrlPkg::*;

    ctrlWordT idEx;
    memCtrlT  exMemMem;
    wbCtrlT   exMemWb;
    wbCtrlT   memWb;
    logic     issue;

    // no stall downstream, so every queued word is taken at once.
    assign pop   = notEmpty;
    assign issue = pop && !illegal;

    // ------------------------------
    // ID/EX, EX/MEM, MEM/WB
    // ------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            idEx     <= '0;
            exMemMem <= '0;
            exMemWb  <= '0;
            memWb    <= '0;
        end else begin
            idEx           <= ctrl;
            idEx.ex.valid  <= issue;
            idEx.mem.valid <= issue;
            idEx.wb.valid  <= issue;

            exMemMem       <= idEx.mem;
            exMemWb        <= idEx.wb;

            memWb          <= exMemWb;
        end
    end

    assign exCtrl  = idEx.ex;
    assign memCtrl = exMemMem;
    assign wbCtrl  = memWb;

    // illegal words leave a bubble and are only counted.
    always_ff @(posedge clk) begin
        if (rst) begin
            retiredCount <= 32'd0;
            illegalCount <= 32'd0;
        end else begin
            if (memWb.valid) begin
                retiredCount <= retiredCount + 32'd1;
            end
            if (pop && illegal) begin
                illegalCount <= illegalCount + 32'd1;
            end
        end
    end

endmodule

// ==== mipsCtrlTop.sv ====
// MIPS control path top
`timescale 1ns/1ps

module mipsCtrlTop #(
    parameter int QueueDepth = 4
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                psel,
    input  logic                penable,
    input  logic                pwrite,
    input  logic [3:0]          paddr,
    input  logic [31:0]         pwdata,
    output logic [31:0]         prdata,
    output logic                pready,
    output logic                pslverr,
    output mipsCtrlPkg::exCtrlT  exCtrl,
    output mipsCtrlPkg::memCtrlT memCtrl,
    output mipsCtrlPkg::wbCtrlT  wbCtrl
);
    import mipsCtrlPkg::*;

    logic        push;
    logic [31:0] pushData;
    logic        full;
    logic        pop;
    logic        notEmpty;
    logic [31:0] headData;
    ctrlWordT    ctrl;
    logic        illegal;
    logic [31:0] retiredCount;
    logic [31:0] illegalCount;

    instrApbPort u_port (
        .clk          (clk),
        .rst          (rst),
        .psel         (psel),
        .penable      (penable),
        .pwrite       (pwrite),
        .paddr        (paddr),
        .pwdata       (pwdata),
        .prdata       (prdata),
        .pready       (pready),
        .pslverr      (pslverr),
        .full         (full),
        .push         (push),
        .pushData     (pushData),
        .retiredCount (retiredCount),
        .illegalCount (illegalCount)
    );

    instrQueue #(
        .QueueDepth (QueueDepth)
    ) u_queue (
        .clk      (clk),
        .rst      (rst),
        .push     (push),
        .pushData (pushData),
        .full     (full),
        .pop      (pop),
        .notEmpty (notEmpty),
        .headData (headData)
    );

    ctrlDecoder u_decoder (
        .instr   (headData),
        .ctrl    (ctrl),
        .illegal (illegal)
    );

    ctrlPipeline u_pipe (
        .clk          (clk),
        .rst          (rst),
        .notEmpty     (notEmpty),
        .pop          (pop),
        .ctrl         (ctrl),
        .illegal      (illegal),
        .exCtrl       (exCtrl),
        .memCtrl      (memCtrl),
        .wbCtrl       (wbCtrl),
        .retiredCount (retiredCount),
        .illegalCount (illegalCount)
    );

endmodule

// ==== mipsCtrl_asserts.sv ====
// APB and stage assertions
`timescale 1ns/1ps

module mipsCtrlAsserts (
    input logic                 clk,
    input logic                 rst,
    input logic                 psel,
    input logic [31:0]          prdata,
    input logic                 pready,
    input logic                 pslverr,
    input mipsCtrlPkg::exCtrlT  exCtrl,
    input mipsCtrlPkg::memCtrlT memCtrl,
    input mipsCtrlPkg::wbCtrlT  wbCtrl
);
    import mipsCtrlPkg::*;

    int errorCount = 0;

    // ------------------------------
    // APB outputs
    // ------------------------------
    apbIdleStable: assert property (@(posedge clk) disable iff (rst)
        (!psel && !$past(psel)) |-> $stable({prdata, pready, pslverr}))
        else begin
            errorCount++;
            $error("APB outputs changed while psel was low");
        end

    // each stage is fed by the one before it.
    memAfterEx: assert property (@(posedge clk) disable iff (rst)
        memCtrl.valid |-> $past(exCtrl.valid))
        else begin
            errorCount++;
            $error("memCtrl valid without exCtrl valid one cycle earlier");
        end

    wbAfterMem: assert property (@(posedge clk) disable iff (rst)
        wbCtrl.valid |-> $past(memCtrl.valid))
        else begin
            errorCount++;
            $error("wbCtrl valid without memCtrl valid one cycle earlier");
        end

endmodule

bind mipsCtrlTop mipsCtrlAsserts u_asserts (
    .clk     (clk),
    .rst     (rst),
    .psel    (psel),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .exCtrl  (exCtrl),
    .memCtrl (memCtrl),
    .wbCtrl  (wbCtrl)
);

// ==== mipsCtrlTb.sv ====
// Control path testbench
`timescale 1ns/1ps

module mipsCtrlTb;
    import mipsCtrlPkg::*;

    localparam int QueueDepth  = 4;
    localparam int NumIllegal  = 6;
    localparam int NumBurst    = 40;
    localparam int NumXfers    = 10 + NumIllegal + NumBurst + 12;
    localparam int TimeoutCyc  = NumXfers * 20 + 200;   // 20 cycles per transfer plus margin.
    localparam int SampleDelay = 1;                     // settle time after the falling edge.

    logic        clk = 1'b0;
    logic        rst;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [3:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    exCtrlT      exCtrl;
    memCtrlT     memCtrl;
    wbCtrlT      wbCtrl;

    exCtrlT      exQ[$];
    memCtrlT     memQ[$];
    wbCtrlT      wbQ[$];
    logic [31:0] lcgState = 32'h1806_1449;
    int          expLegal = 0;
    int          expIllegal = 0;
    logic        prevExValid = 1'b0;
    logic        prevMemValid = 1'b0;

    always #4 clk = ~clk;

    mipsCtrlTop #(
        .QueueDepth (QueueDepth)
    ) u_dut (
        .clk     (clk),
        .rst     (rst),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .exCtrl  (exCtrl),
        .memCtrl (memCtrl),
        .wbCtrl  (wbCtrl)
    );

    // ------------------------------
    // reporting and compares
    // ------------------------------
    task automatic stopRun(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic checkEx(input string name, input exCtrlT expV, input exCtrlT actV);
        if (actV !== expV) begin
            stopRun($sformatf("FAILED %s: expected %h, actual %h", name, expV, actV));
        end
    endtask

    task automatic checkMem(input string name, input memCtrlT expV, input memCtrlT actV);
        if (actV !== expV) begin
            stopRun($sformatf("FAILED %s: expected %h, actual %h", name, expV, actV));
        end
    endtask

    task automatic checkWb(input string name, input wbCtrlT expV, input wbCtrlT actV);
        if (actV !== expV) begin
            stopRun($sformatf("FAILED %s: expected %h, actual %h", name, expV, actV));
        end
    endtask

    task automatic checkWord(input string name, input logic [31:0] expV,
                             input logic [31:0] actV);
        if (actV !== expV) begin
            stopRun($sformatf("FAILED %s: expected %h, actual %h", name, expV, actV));
        end
    endtask

    // ------------------------------
    // stimulus and model
    // ------------------------------
    function automatic logic [31:0] nextRand();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    function automatic int randomKind();
        logic [31:0] r;
        r = nextRand();
        if (r[31:29] == 3'd0) begin
            return 10 + int'(r[28]);              // roughly one in eight illegal.
        end
        return int'(r[27:24]) % 10;
    endfunction

    // kinds 0 to 9 are legal, 10 and 11 bad opcode and bad funct.
    function automatic logic [31:0] makeInstr(input int kind, input logic [31:0] r);
        case (kind)
            0:       return {opLw, r[25:0]};
            1:       return {opSw, r[25:0]};
            2:       return {opBne, r[25:0]};
            3:       return {opXori, r[25:0]};
            4:       return {opJ, r[25:0]};
            5:       return {opJal, r[25:0]};
            6:       return {opRtype, r[25:6], fnAdd};
            7:       return {opRtype, r[25:6], fnSub};
            8:       return {opRtype, r[25:6], fnSlt};
            9:       return {opRtype, r[25:6], fnJr};
            10:      return {6'h3f, r[25:0]};
            default: return {opRtype, r[25:6], 6'h3f};
        endcase
    endfunction

    // f = {aluSrc, regDst, memWrite, branch, jump, regWrite, memToReg, link}.
    function automatic ctrlWordT tableRow(input aluCtrlE alu, input logic [7:0] f);
        ctrlWordT c;
        c     = '0;
        c.ex  = '{valid: 1'b1, aluCtrl: alu, aluSrc: f[7], regDst: f[6]};
        c.mem = '{valid: 1'b1, memWrite: f[5], branch: f[4], jump: f[3]};
        c.wb  = '{valid: 1'b1, regWrite: f[2], memToReg: f[1], link: f[0]};
        return c;
    endfunction

    function automatic logic modelDecode(input logic [31:0] instr, output ctrlWordT c);
        c = '0;
        case (instr[31:26])
            opLw:    c = tableRow(aluAdd, 8'b1000_0110);
            opSw:    c = tableRow(aluAdd, 8'b1010_0000);
            opBne:   c = tableRow(aluSub, 8'b0001_0000);
            opXori:  c = tableRow(aluXor, 8'b1000_0100);
            opJ:     c = tableRow(aluPass, 8'b0000_1000);
            opJal:   c = tableRow(aluPass, 8'b0000_1101);
            opRtype: begin
                case (instr[5:0])
                    fnAdd:   c = tableRow(aluAdd, 8'b0100_0100);
                    fnSub:   c = tableRow(aluSub, 8'b0100_0100);
                    fnSlt:   c = tableRow(aluSlt, 8'b0100_0100);
                    fnJr:    c = tableRow(aluPass, 8'b0000_1000);
                    default: return 1'b0;
                endcase
            end
            default: return 1'b0;
        endcase
        return 1'b1;
    endfunction

    // ------------------------------
    // APB master
    // ------------------------------
    task automatic apbXfer(input logic wr, input logic [3:0] addr, input logic [31:0] wdata,
                           output logic [31:0] rdata, output logic err);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clk);
        penable = 1'b1;
        #SampleDelay;
        while (!pready) begin                     // wait states on a full queue.
            @(negedge clk);
            #SampleDelay;
        end
        rdata = prdata;
        err   = pslverr;
    endtask

    task automatic apbIdle();
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic writeInstr(input logic [31:0] w);
        logic [31:0] rd;
        logic        err;
        ctrlWordT    c;
        apbXfer(1'b1, regPush, w, rd, err);
        checkWord("instruction push pslverr", 32'd0, 32'(err));
        if (modelDecode(w, c)) begin
            exQ.push_back(c.ex);
            memQ.push_back(c.mem);
            wbQ.push_back(c.wb);
            expLegal++;
        end else begin
            expIllegal++;
        end
    endtask

    task automatic readReg(input string name, input logic [3:0] addr, input logic [31:0] expV);
        logic [31:0] rd;
        logic        err;
        apbXfer(1'b0, addr, 32'd0, rd, err);
        apbIdle();
        checkWord({name, " pslverr"}, 32'd0, 32'(err));
        checkWord(name, expV, rd);
    endtask

    task automatic badAccess(input string name, input logic wr, input logic [3:0] addr);
        logic [31:0] rd;
        logic        err;
        apbXfer(wr, addr, 32'hdead_beef, rd, err);
        apbIdle();
        checkWord(name, 32'd1, 32'(err));
    endtask

    task automatic waitDrain();
        while (exQ.size() != 0 || memQ.size() != 0 || wbQ.size() != 0) begin
            @(negedge clk);
        end
    endtask

    // ------------------------------
    // scoreboard
    // ------------------------------
    always @(negedge clk) begin
        if (!rst) begin
            if (u_dut.u_asserts.errorCount != 0) begin
                stopRun("a bound protocol or stage-order assertion failed");
            end
            checkWord("stage offset EX to MEM", 32'(prevExValid), 32'(memCtrl.valid));
            checkWord("stage offset MEM to WB", 32'(prevMemValid), 32'(wbCtrl.valid));
            if (exCtrl.valid) begin
                if (exQ.size() == 0) begin
                    stopRun("exCtrl went valid with no legal instruction outstanding");
                end
                checkEx("exCtrl slice", exQ.pop_front(), exCtrl);
            end
            if (memCtrl.valid) begin
                if (memQ.size() == 0) begin
                    stopRun("memCtrl went valid with no legal instruction outstanding");
                end
                checkMem("memCtrl slice", memQ.pop_front(), memCtrl);
            end
            if (wbCtrl.valid) begin
                if (wbQ.size() == 0) begin
                    stopRun("wbCtrl went valid with no legal instruction outstanding");
                end
                checkWb("wbCtrl slice", wbQ.pop_front(), wbCtrl);
            end
            prevExValid  = exCtrl.valid;
            prevMemValid = memCtrl.valid;
        end
    end

    initial begin
        repeat (TimeoutCyc) @(posedge clk);
        $display("Watchdog expired before all transfers completed");
        $display("Simulation failed");
        $fatal(1);
    end

    initial begin
        int i;
        int kind;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        rst     = 1'b1;
        repeat (10) @(negedge clk);
        rst = 1'b0;

        // every legal instruction on its own.
        for (i = 0; i < 10; i++) begin
            writeInstr(makeInstr(i, nextRand()));
            apbIdle();
            waitDrain();
        end

        // illegal words only bump the counter.
        for (i = 0; i < NumIllegal; i++) begin
            writeInstr(makeInstr(10 + (i % 2), nextRand()));
            apbIdle();
        end
        readReg("illegal count", regIllegal, 32'(expIllegal));

        // back-to-back burst with random words.
        for (i = 0; i < NumBurst; i++) begin
            kind = randomKind();
            writeInstr(makeInstr(kind, nextRand()));
        end
        apbIdle();
        waitDrain();

        readReg("retired count", regRetired, 32'(expLegal));
        readReg("illegal count after burst", regIllegal, 32'(expIllegal));
        badAccess("write to retired count", 1'b1, regRetired);
        badAccess("write to illegal count", 1'b1, regIllegal);
        badAccess("read of unmapped offset", 1'b0, 4'hc);
        badAccess("write to unmapped offset", 1'b1, 4'hc);
        readReg("retired count unchanged", regRetired, 32'(expLegal));
        readReg("illegal count unchanged", regIllegal, 32'(expIllegal));

        if (u_dut.u_asserts.errorCount == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
mipsCtrlPkg.sv
instrApbPort.sv
instrQueue.sv
ctrlDecoder.sv
ctrlPipeline.sv
mipsCtrlTop.sv
mipsCtrl_asserts.sv
mipsCtrlTb.sv

// ==== Bender.yml ====
package:
  name: mips_ctrl

sources:
  - files:
      - mipsCtrlPkg.sv
      - instrApbPort.sv
      - instrQueue.sv
      - ctrlDecoder.sv
      - ctrlPipeline.sv
      - mipsCtrlTop.sv
  - target: test
    files:
      - mipsCtrl_asserts.sv
      - mipsCtrlTb.sv
